// ==== common/tile_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing of one TCDM tile and its cluster
// Every count must be a power of two, since the
// address fields are cut from them directly
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// Cores per tile, also the number of slave ports
`define TILE_CORES 2

// SRAM banks inside one tile
`define TILE_BANKS 4

// Tiles in the whole cluster
`define TILE_COUNT 4

// Depth of one bank in words
`define TILE_BANK_WORDS 256

// Word width in bits
`define TILE_DATA_WIDTH 32

`endif

// ==== common/tile_addr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address field types of the interleaved TCDM
// Only the low TCDM bits of a core address are
// decoded, anything above them is ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tile_config.svh"

package tile_addr_pkg;

  localparam int unsigned ByteOffBits = $clog2(`TILE_DATA_WIDTH / 8);

  typedef logic [ByteOffBits-1:0]              byte_off_t;
  typedef logic [$clog2(`TILE_BANKS)-1:0]      bank_idx_t;
  typedef logic [$clog2(`TILE_COUNT)-1:0]      tile_id_t;
  typedef logic [$clog2(`TILE_BANK_WORDS)-1:0] row_addr_t;

  // Core view, top to bottom: row, tile, bank, byte
  typedef struct packed {
    row_addr_t row;
    tile_id_t  tile;
    bank_idx_t bank;
    byte_off_t byte_off;
  } tcdm_addr_t;

  localparam int unsigned TcdmAddrBits = $bits(tcdm_addr_t);

  // Word address once the tile field is gone
  typedef struct packed {
    row_addr_t row;
    bank_idx_t bank;
  } tile_addr_t;

  typedef enum logic {
    ROUTE_LOCAL,
    ROUTE_REMOTE
  } route_e;

endpackage

// ==== common/tile_mem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request and response payloads of the tile
// Crossbar initiators 0 and 1 are the cores,
// 2 and 3 are the slave ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tile_config.svh"

package tile_mem_pkg;

  import tile_addr_pkg::*;

  localparam int unsigned NumIni = 2 * `TILE_CORES;

  typedef logic [`TILE_DATA_WIDTH-1:0]   data_t;
  typedef logic [`TILE_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [$clog2(NumIni)-1:0]     ini_idx_t;
  typedef logic [$clog2(`TILE_CORES)-1:0] core_idx_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    data_t       data;
    strb_t       strb;
  } core_req_t;

  // Who sent a slave request, echoed on its response
  typedef struct packed {
    tile_id_t  tile;
    core_idx_t core;
  } slave_meta_t;

  typedef struct packed {
    tile_addr_t  addr;
    logic        we;
    data_t       data;
    strb_t       strb;
    slave_meta_t ini;
  } slave_req_t;

  typedef struct packed {
    data_t       data;
    slave_meta_t ini;
  } slave_resp_t;

  typedef struct packed {
    row_addr_t row;
    logic      we;
    data_t     data;
    strb_t     strb;
    ini_idx_t  ini;
  } bank_req_t;

  typedef struct packed {
    data_t    data;
    ini_idx_t ini;
  } bank_resp_t;

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT_LOCAL,
    PORT_WAIT_REMOTE
  } port_state_e;

endpackage

// ==== hw/tile_cfg_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile ID and remote-block registers
// A write lands at the edge, decode follows a
// cycle later; readback is {block, tile ID}
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tile_cfg_regs (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     cfg_we_i,
  input  tile_addr_pkg::tile_id_t                  cfg_tile_id_i,
  input  logic                                     cfg_block_i,
  output tile_addr_pkg::tile_id_t                  tile_id_o,
  output logic                                     remote_block_o,
  output logic [$bits(tile_addr_pkg::tile_id_t):0] cfg_rdata_o
);

  import tile_addr_pkg::*;

  tile_id_t tile_id_q;
  logic     block_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tile_id_q <= '0;
      block_q   <= 1'b0;
    end else if (cfg_we_i) begin
      tile_id_q <= cfg_tile_id_i;
      block_q   <= cfg_block_i;
    end
  end

  assign tile_id_o      = tile_id_q;
  assign remote_block_o = block_q;
  assign cfg_rdata_o    = {block_q, tile_id_q};

endmodule

// ==== hw/core_port_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-core router to local banks or master port
// One request in flight per core; ready stays low
// until the matching response has come back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core_port_router #(
  parameter int unsigned CoreIdx = 0
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  tile_addr_pkg::tile_id_t tile_id_i,
  input  logic                    core_req_valid_i,
  input  tile_mem_pkg::core_req_t core_req_i,
  output logic                    core_req_ready_o,
  output logic                    core_resp_valid_o,
  output tile_mem_pkg::data_t     core_resp_data_o,
  output logic                    xbar_req_valid_o,
  output tile_mem_pkg::bank_req_t xbar_req_o,
  output tile_addr_pkg::bank_idx_t xbar_bank_o,
  input  logic                    xbar_req_ready_i,
  input  logic                    xbar_resp_valid_i,
  input  tile_mem_pkg::data_t     xbar_resp_data_i,
  output logic                    mst_req_valid_o,
  output tile_mem_pkg::core_req_t mst_req_o,
  input  logic                    mst_req_ready_i,
  input  logic                    mst_resp_valid_i,
  input  tile_mem_pkg::data_t     mst_resp_data_i
);

  import tile_addr_pkg::*;
  import tile_mem_pkg::*;

  tcdm_addr_t  addr;
  route_e      route;
  port_state_e state_q;
  logic        idle;
  logic        accept;

  assign addr  = tcdm_addr_t'(core_req_i.addr[TcdmAddrBits-1:0]);
  assign route = (addr.tile == tile_id_i) ? ROUTE_LOCAL : ROUTE_REMOTE;
  assign idle  = (state_q == PORT_IDLE);

  assign xbar_req_valid_o = core_req_valid_i && idle && (route == ROUTE_LOCAL);
  assign mst_req_valid_o  = core_req_valid_i && idle && (route == ROUTE_REMOTE);
  assign core_req_ready_o = idle && ((route == ROUTE_LOCAL) ? xbar_req_ready_i
                                                            : mst_req_ready_i);
  assign accept = core_req_valid_i && core_req_ready_o;

  // Local side drops the tile field
  assign xbar_bank_o = addr.bank;
  assign xbar_req_o  = '{
    row:  addr.row,
    we:   core_req_i.we,
    data: core_req_i.data,
    strb: core_req_i.strb,
    ini:  ini_idx_t'(CoreIdx)
  };

  // Bank and tile swap places for the upper-level network
  always_comb begin
    mst_req_o = core_req_i;
    mst_req_o.addr[TcdmAddrBits-1:0] = {addr.row, addr.bank, addr.tile, addr.byte_off};
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= PORT_IDLE;
    end else begin
      case (state_q)
        PORT_IDLE:
          if (accept) begin
            state_q <= (route == ROUTE_LOCAL) ? PORT_WAIT_LOCAL : PORT_WAIT_REMOTE;
          end
        PORT_WAIT_LOCAL:
          if (xbar_resp_valid_i) state_q <= PORT_IDLE;
        PORT_WAIT_REMOTE:
          if (mst_resp_valid_i) state_q <= PORT_IDLE;
        default:
          state_q <= PORT_IDLE;
      endcase
    end
  end

  assign core_resp_valid_o = (state_q == PORT_WAIT_LOCAL && xbar_resp_valid_i) ||
                             (state_q == PORT_WAIT_REMOTE && mst_resp_valid_i);
  assign core_resp_data_o  = (state_q == PORT_WAIT_REMOTE) ? mst_resp_data_i
                                                           : xbar_resp_data_i;

endmodule

// ==== tcdm/local_xbar.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core and slave ports to banks, round-robin each
// Banks answer one cycle after the grant, so slave
// tags are held for exactly that one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "tile_config.svh"

module local_xbar (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                                         remote_block_i,
  input  logic [`TILE_CORES-1:0]                       core_req_valid_i,
  input  tile_mem_pkg::bank_req_t   [`TILE_CORES-1:0]  core_req_i,
  input  tile_addr_pkg::bank_idx_t  [`TILE_CORES-1:0]  core_bank_i,
  output logic [`TILE_CORES-1:0]                       core_req_ready_o,
  output logic [`TILE_CORES-1:0]                       core_resp_valid_o,
  output tile_mem_pkg::data_t       [`TILE_CORES-1:0]  core_resp_data_o,
  input  logic [`TILE_CORES-1:0]                       slv_req_valid_i,
  input  tile_mem_pkg::slave_req_t  [`TILE_CORES-1:0]  slv_req_i,
  output logic [`TILE_CORES-1:0]                       slv_req_ready_o,
  output logic [`TILE_CORES-1:0]                       slv_resp_valid_o,
  output tile_mem_pkg::slave_resp_t [`TILE_CORES-1:0]  slv_resp_o,
  output logic [`TILE_BANKS-1:0]                       bank_req_valid_o,
  output tile_mem_pkg::bank_req_t   [`TILE_BANKS-1:0]  bank_req_o,
  input  logic [`TILE_BANKS-1:0]                       bank_resp_valid_i,
  input  tile_mem_pkg::bank_resp_t  [`TILE_BANKS-1:0]  bank_resp_i
);

  import tile_addr_pkg::*;
  import tile_mem_pkg::*;

  localparam int unsigned NumCores = `TILE_CORES;
  localparam int unsigned NumBanks = `TILE_BANKS;

  logic        [NumIni-1:0]   ini_valid;
  bank_idx_t   [NumIni-1:0]   ini_bank;
  bank_req_t   [NumIni-1:0]   ini_req;
  logic        [NumIni-1:0]   ini_ready;
  ini_idx_t    [NumBanks-1:0] rr_q;
  ini_idx_t    [NumBanks-1:0] win;
  logic        [NumIni-1:0]   resp_valid;
  data_t       [NumIni-1:0]   resp_data;
  slave_meta_t [NumCores-1:0] slv_meta_q;

  // Flatten both port kinds into one initiator list
  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      ini_valid[c] = core_req_valid_i[c];
      ini_bank[c]  = core_bank_i[c];
      ini_req[c]   = core_req_i[c];
    end
    for (int s = 0; s < NumCores; s++) begin
      ini_valid[NumCores+s] = slv_req_valid_i[s] && !remote_block_i;
      ini_bank[NumCores+s]  = slv_req_i[s].addr.bank;
      ini_req[NumCores+s]   = '{
        row:  slv_req_i[s].addr.row,
        we:   slv_req_i[s].we,
        data: slv_req_i[s].data,
        strb: slv_req_i[s].strb,
        ini:  ini_idx_t'(NumCores + s)
      };
    end
  end

  // First requester at or after the pointer wins the bank
  always_comb begin
    int cand;
    ini_ready = '0;
    for (int b = 0; b < NumBanks; b++) begin
      bank_req_valid_o[b] = 1'b0;
      win[b] = rr_q[b];
      for (int k = 0; k < NumIni; k++) begin
        cand = (int'(rr_q[b]) + k) % NumIni;
        if (!bank_req_valid_o[b] && ini_valid[cand] && ini_bank[cand] == bank_idx_t'(b)) begin
          bank_req_valid_o[b] = 1'b1;
          win[b] = ini_idx_t'(cand);
        end
      end
      bank_req_o[b] = ini_req[win[b]];
      if (bank_req_valid_o[b]) ini_ready[win[b]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (bank_req_valid_o[b]) rr_q[b] <= ini_idx_t'(win[b] + 1'b1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int s = 0; s < NumCores; s++) begin
      if (slv_req_valid_i[s] && slv_req_ready_o[s]) slv_meta_q[s] <= slv_req_i[s].ini;
    end
  end

  // Each initiator has at most one bank answering per cycle
  always_comb begin
    resp_valid = '0;
    resp_data  = '0;
    for (int b = 0; b < NumBanks; b++) begin
      if (bank_resp_valid_i[b]) begin
        resp_valid[bank_resp_i[b].ini] = 1'b1;
        resp_data[bank_resp_i[b].ini]  = bank_resp_i[b].data;
      end
    end
  end

  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      core_req_ready_o[c]  = ini_ready[c];
      core_resp_valid_o[c] = resp_valid[c];
      core_resp_data_o[c]  = resp_data[c];
      slv_req_ready_o[c]   = ini_ready[NumCores+c];
      slv_resp_valid_o[c]  = resp_valid[NumCores+c];
      slv_resp_o[c]        = '{data: resp_data[NumCores+c], ini: slv_meta_q[c]};
    end
  end

endmodule

// ==== tcdm/tcdm_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port SRAM bank with byte strobes
// Every access returns the old word a cycle later,
// writes included
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "tile_config.svh"

module tcdm_bank (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_valid_i,
  input  tile_mem_pkg::bank_req_t  req_i,
  output logic                     resp_valid_o,
  output tile_mem_pkg::bank_resp_t resp_o
);

  import tile_mem_pkg::*;

  localparam int unsigned NumBytes = `TILE_DATA_WIDTH / 8;

  data_t    mem [`TILE_BANK_WORDS];
  data_t    rdata_q;
  ini_idx_t ini_q;
  logic     valid_q;

  // Read before write on the same row
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_q <= mem[req_i.row];
      ini_q   <= req_i.ini;
      for (int i = 0; i < NumBytes; i++) begin
        if (req_i.we && req_i.strb[i]) begin
          mem[req_i.row][8*i +: 8] <= req_i.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_o       = '{data: rdata_q, ini: ini_q};

endmodule

// ==== hw/tcdm_tile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One TCDM tile: routers, crossbar and banks
// Responses carry no ready and must be taken in
// the cycle they are valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "tile_config.svh"

module tcdm_tile (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic [`TILE_CORES-1:0]                      core_req_valid_i,
  input  tile_mem_pkg::core_req_t   [`TILE_CORES-1:0] core_req_i,
  output logic [`TILE_CORES-1:0]                      core_req_ready_o,
  output logic [`TILE_CORES-1:0]                      core_resp_valid_o,
  output tile_mem_pkg::data_t       [`TILE_CORES-1:0] core_resp_data_o,
  output logic [`TILE_CORES-1:0]                      mst_req_valid_o,
  output tile_mem_pkg::core_req_t   [`TILE_CORES-1:0] mst_req_o,
  input  logic [`TILE_CORES-1:0]                      mst_req_ready_i,
  input  logic [`TILE_CORES-1:0]                      mst_resp_valid_i,
  input  tile_mem_pkg::data_t       [`TILE_CORES-1:0] mst_resp_data_i,
  input  logic [`TILE_CORES-1:0]                      slv_req_valid_i,
  input  tile_mem_pkg::slave_req_t  [`TILE_CORES-1:0] slv_req_i,
  output logic [`TILE_CORES-1:0]                      slv_req_ready_o,
  output logic [`TILE_CORES-1:0]                      slv_resp_valid_o,
  output tile_mem_pkg::slave_resp_t [`TILE_CORES-1:0] slv_resp_o,
  input  logic                                        cfg_we_i,
  input  tile_addr_pkg::tile_id_t                     cfg_tile_id_i,
  input  logic                                        cfg_block_i,
  output logic [$bits(tile_addr_pkg::tile_id_t):0]    cfg_rdata_o
);

  import tile_addr_pkg::*;
  import tile_mem_pkg::*;

  tile_id_t                       tile_id;
  logic                           remote_block;
  logic       [`TILE_CORES-1:0]   xbar_req_valid;
  bank_req_t  [`TILE_CORES-1:0]   xbar_req;
  bank_idx_t  [`TILE_CORES-1:0]   xbar_bank;
  logic       [`TILE_CORES-1:0]   xbar_req_ready;
  logic       [`TILE_CORES-1:0]   xbar_resp_valid;
  data_t      [`TILE_CORES-1:0]   xbar_resp_data;
  logic       [`TILE_BANKS-1:0]   bank_req_valid;
  bank_req_t  [`TILE_BANKS-1:0]   bank_req;
  logic       [`TILE_BANKS-1:0]   bank_resp_valid;
  bank_resp_t [`TILE_BANKS-1:0]   bank_resp;

  tile_cfg_regs cfg_regs_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_tile_id_i  (cfg_tile_id_i),
    .cfg_block_i    (cfg_block_i),
    .tile_id_o      (tile_id),
    .remote_block_o (remote_block),
    .cfg_rdata_o    (cfg_rdata_o)
  );

  for (genvar c = 0; c < `TILE_CORES; c++) begin : gen_router
    core_port_router #(
      .CoreIdx (c)
    ) router_i (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .tile_id_i         (tile_id),
      .core_req_valid_i  (core_req_valid_i[c]),
      .core_req_i        (core_req_i[c]),
      .core_req_ready_o  (core_req_ready_o[c]),
      .core_resp_valid_o (core_resp_valid_o[c]),
      .core_resp_data_o  (core_resp_data_o[c]),
      .xbar_req_valid_o  (xbar_req_valid[c]),
      .xbar_req_o        (xbar_req[c]),
      .xbar_bank_o       (xbar_bank[c]),
      .xbar_req_ready_i  (xbar_req_ready[c]),
      .xbar_resp_valid_i (xbar_resp_valid[c]),
      .xbar_resp_data_i  (xbar_resp_data[c]),
      .mst_req_valid_o   (mst_req_valid_o[c]),
      .mst_req_o         (mst_req_o[c]),
      .mst_req_ready_i   (mst_req_ready_i[c]),
      .mst_resp_valid_i  (mst_resp_valid_i[c]),
      .mst_resp_data_i   (mst_resp_data_i[c])
    );
  end

  local_xbar xbar_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .remote_block_i    (remote_block),
    .core_req_valid_i  (xbar_req_valid),
    .core_req_i        (xbar_req),
    .core_bank_i       (xbar_bank),
    .core_req_ready_o  (xbar_req_ready),
    .core_resp_valid_o (xbar_resp_valid),
    .core_resp_data_o  (xbar_resp_data),
    .slv_req_valid_i   (slv_req_valid_i),
    .slv_req_i         (slv_req_i),
    .slv_req_ready_o   (slv_req_ready_o),
    .slv_resp_valid_o  (slv_resp_valid_o),
    .slv_resp_o        (slv_resp_o),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_o        (bank_req),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_i       (bank_resp)
  );

  for (genvar b = 0; b < `TILE_BANKS; b++) begin : gen_bank
    tcdm_bank bank_i (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_valid_i  (bank_req_valid[b]),
      .req_i        (bank_req[b]),
      .resp_valid_o (bank_resp_valid[b]),
      .resp_o       (bank_resp[b])
    );
  end

endmodule

// ==== testbench/tb_tcdm_tile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for one TCDM tile, driven from a vector file
// Run from the project root so the vector path resolves
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_tcdm_tile;

  import tile_addr_pkg::*;
  import tile_mem_pkg::*;

  logic                  clk_i = 1'b0;
  logic                  reset_i;
  logic [1:0]            core_req_valid;
  core_req_t [1:0]       core_req;
  logic [1:0]            core_req_ready;
  logic [1:0]            core_resp_valid;
  data_t [1:0]           core_resp_data;
  logic [1:0]            mst_req_valid;
  core_req_t [1:0]       mst_req;
  logic [1:0]            mst_req_ready;
  logic [1:0]            mst_resp_valid;
  data_t [1:0]           mst_resp_data;
  logic [1:0]            slv_req_valid;
  slave_req_t [1:0]      slv_req;
  logic [1:0]            slv_req_ready;
  logic [1:0]            slv_resp_valid;
  slave_resp_t [1:0]     slv_resp;
  logic                  cfg_we;
  tile_id_t              cfg_tile_id;
  logic                  cfg_block;
  logic [2:0]            cfg_rdata;

  // Reference memory by tile word address
  logic [31:0] ref_mem [1024];
  bit          known [1024];
  logic [1:0]  tile_model;
  int          errors = 0;
  int          cycles = 0;
  int          limit = 0;

  byte         kinds [$];
  int          ports [$];
  logic [31:0] addrs [$];
  logic [31:0] datas [$];
  logic [3:0]  strbs [$];
  logic [31:0] expects [$];

  tcdm_tile tcdm_tile_i (
    .clk_i (clk_i), .reset_i (reset_i),
    .core_req_valid_i (core_req_valid), .core_req_i (core_req),
    .core_req_ready_o (core_req_ready), .core_resp_valid_o (core_resp_valid),
    .core_resp_data_o (core_resp_data),
    .mst_req_valid_o (mst_req_valid), .mst_req_o (mst_req),
    .mst_req_ready_i (mst_req_ready), .mst_resp_valid_i (mst_resp_valid),
    .mst_resp_data_i (mst_resp_data),
    .slv_req_valid_i (slv_req_valid), .slv_req_i (slv_req),
    .slv_req_ready_o (slv_req_ready), .slv_resp_valid_o (slv_resp_valid),
    .slv_resp_o (slv_resp),
    .cfg_we_i (cfg_we), .cfg_tile_id_i (cfg_tile_id), .cfg_block_i (cfg_block),
    .cfg_rdata_o (cfg_rdata)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (limit > 0) begin
      cycles++;
      if (cycles > limit) begin
        $display("Run stopped: cycle limit of %0d reached before the vectors finished", limit);
        $display("Some tests failed");
        $finish;
      end
    end
  end

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Old word out, merged word stored
  task automatic update_ref(logic [9:0] idx, logic [31:0] data, logic [3:0] strb,
                            output logic [31:0] old_word, output bit was_known);
    old_word  = ref_mem[idx];
    was_known = known[idx];
    if (strb != 0) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) ref_mem[idx][8*i +: 8] = data[8*i +: 8];
      end
      known[idx] = (strb == 4'hf) || known[idx];
    end
  endtask

  task automatic core_access(int p, logic [31:0] addr, logic [31:0] data,
                             logic [3:0] strb, logic [31:0] remote_data);
    logic [31:0] old_word;
    logic [31:0] swapped;
    bit          was_known;
    bit          is_local;
    int          gap;
    is_local = (addr[5:4] == tile_model);
    swapped  = {addr[31:6], addr[3:2], addr[5:4], addr[1:0]};
    @(posedge clk_i);
    #1;
    core_req_valid[p]   = 1'b1;
    core_req[p].addr    = addr;
    core_req[p].we      = (strb != 0);
    core_req[p].data    = data;
    core_req[p].strb    = strb;
    @(negedge clk_i);
    while (!core_req_ready[p]) @(negedge clk_i);
    if (is_local) begin
      update_ref({addr[13:6], addr[3:2]}, data, strb, old_word, was_known);
    end else begin
      check_value("mst_req_valid_o", 1, 32'(mst_req_valid[p]));
      check_value("mst_req_o.addr", swapped, mst_req[p].addr);
      check_value("mst_req_o.we", 32'(strb != 0), 32'(mst_req[p].we));
      check_value("mst_req_o.data", data, mst_req[p].data);
      check_value("mst_req_o.strb", 32'(strb), 32'(mst_req[p].strb));
    end
    @(posedge clk_i);
    #1;
    core_req_valid[p] = 1'b0;
    if (is_local) begin
      @(negedge clk_i);
      check_value("core_req_ready_o", 0, 32'(core_req_ready[p]));
      check_value("core_resp_valid_o", 1, 32'(core_resp_valid[p]));
      if (was_known) check_value("core_resp_data_o", old_word, core_resp_data[p]);
    end else begin
      gap = $urandom % 3;
      repeat (gap) @(posedge clk_i);
      #1;
      mst_resp_valid[p] = 1'b1;
      mst_resp_data[p]  = remote_data;
      @(negedge clk_i);
      check_value("core_req_ready_o", 0, 32'(core_req_ready[p]));
      check_value("core_resp_valid_o", 1, 32'(core_resp_valid[p]));
      check_value("core_resp_data_o", remote_data, core_resp_data[p]);
      @(posedge clk_i);
      #1;
      mst_resp_valid[p] = 1'b0;
    end
  endtask

  task automatic drive_slave_req(int p, logic [9:0] taddr, logic [31:0] data,
                                 logic [3:0] strb);
    slv_req_valid[p]     = 1'b1;
    slv_req[p].addr      = taddr;
    slv_req[p].we        = (strb != 0);
    slv_req[p].data      = data;
    slv_req[p].strb      = strb;
    slv_req[p].ini.tile  = tile_id_t'(p + 1);
    slv_req[p].ini.core  = core_idx_t'(p);
  endtask

  // Entered at a falling edge with the request already on the port
  task automatic complete_slave_req(int p, logic [9:0] taddr, logic [31:0] data,
                                    logic [3:0] strb);
    logic [31:0] old_word;
    bit          was_known;
    while (!slv_req_ready[p]) @(negedge clk_i);
    update_ref(taddr, data, strb, old_word, was_known);
    @(posedge clk_i);
    #1;
    slv_req_valid[p] = 1'b0;
    @(negedge clk_i);
    check_value("slv_resp_valid_o", 1, 32'(slv_resp_valid[p]));
    if (was_known) check_value("slv_resp_o.data", old_word, slv_resp[p].data);
    check_value("slv_resp_o.ini.tile", p + 1, 32'(slv_resp[p].ini.tile));
    check_value("slv_resp_o.ini.core", p, 32'(slv_resp[p].ini.core));
  endtask

  task automatic slave_access(int p, logic [9:0] taddr, logic [31:0] data, logic [3:0] strb);
    @(posedge clk_i);
    #1;
    drive_slave_req(p, taddr, data, strb);
    @(negedge clk_i);
    complete_slave_req(p, taddr, data, strb);
  endtask

  task automatic cfg_write(logic [1:0] id, logic block);
    @(posedge clk_i);
    #1;
    cfg_we      = 1'b1;
    cfg_tile_id = id;
    cfg_block   = block;
    @(posedge clk_i);
    #1;
    cfg_we     = 1'b0;
    tile_model = id;
    @(negedge clk_i);
    check_value("cfg_rdata_o", 32'({block, id}), 32'(cfg_rdata));
  endtask

  // Slave request waits out the block while a core read still completes
  task automatic held_slave(int p, logic [9:0] taddr, logic [31:0] data, logic [3:0] strb);
    @(posedge clk_i);
    #1;
    drive_slave_req(p, taddr, data, strb);
    repeat (4) begin
      @(negedge clk_i);
      check_value("slv_req_ready_o", 0, 32'(slv_req_ready[p]));
    end
    core_access(0, 32'h40 | (32'(tile_model) << 4), 0, 4'h0, 0);
    check_value("slv_req_ready_o", 0, 32'(slv_req_ready[p]));
    cfg_write(tile_model, 1'b0);
    complete_slave_req(p, taddr, data, strb);
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    byte   k;
    int    p;
    logic [31:0] a, d, e;
    logic [3:0]  s;
    fd = $fopen("testbench/tile_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file testbench/tile_vectors.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#") begin
        n = $sscanf(line, "%c %d %h %h %h %h", k, p, a, d, s, e);
        if (n == 6) begin
          kinds.push_back(k);
          ports.push_back(p);
          addrs.push_back(a);
          datas.push_back(d);
          strbs.push_back(s);
          expects.push_back(e);
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    void'($urandom(39));
    reset_i        = 1'b1;
    core_req_valid = '0;
    core_req       = '0;
    mst_req_ready  = '1;
    mst_resp_valid = '0;
    mst_resp_data  = '0;
    slv_req_valid  = '0;
    slv_req        = '0;
    cfg_we         = 1'b0;
    cfg_tile_id    = '0;
    cfg_block      = 1'b0;
    tile_model     = '0;
    load_vectors();
    if (kinds.size() == 0) begin
      $display("No vectors were read, nothing to test");
      errors++;
    end
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    limit   = 40 * kinds.size();
    @(negedge clk_i);
    check_value("core_resp_valid_o", 0, 32'(core_resp_valid));
    check_value("mst_req_valid_o", 0, 32'(mst_req_valid));
    check_value("slv_resp_valid_o", 0, 32'(slv_resp_valid));
    check_value("cfg_rdata_o", 0, 32'(cfg_rdata));
    foreach (kinds[i]) begin
      case (kinds[i])
        "c": core_access(ports[i], addrs[i], datas[i], strbs[i], expects[i]);
        "p": fork
          core_access(0, addrs[i], datas[i], strbs[i], expects[i]);
          core_access(1, addrs[i] + 4, datas[i], strbs[i], expects[i]);
        join
        "s": slave_access(ports[i], addrs[i][9:0], datas[i], strbs[i]);
        "g": cfg_write(addrs[i][1:0], datas[i][0]);
        "h": held_slave(ports[i], addrs[i][9:0], datas[i], strbs[i]);
        "i": repeat (3) @(posedge clk_i);
        default: begin
          $display("Vector %0d has an unknown operation kind", i);
          errors++;
        end
      endcase
      repeat ($urandom % 3) @(posedge clk_i);
    end
    $display("Finished %0d vectors with %0d errors", kinds.size(), errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+common
common/tile_addr_pkg.sv
common/tile_mem_pkg.sv
hw/tile_cfg_regs.sv
hw/core_port_router.sv
tcdm/local_xbar.sv
tcdm/tcdm_bank.sv
hw/tcdm_tile.sv
testbench/tb_tcdm_tile.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tile testbench with Verilator from the project root
rm -rf obj_dir sim.log
verilator --binary -f src.f --top-module tb_tcdm_tile -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Simulation failed to build or run"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1

// ==== testbench/tile_vectors.txt ====
# kind port addr data strb expect (hex), kind: c core, p both cores, s slave, g config, h held slave, i idle
# expect is the remote answer for remote core reads, config puts tile ID in addr and block in data
c 0 00000040 11223344 f 00000000
c 0 00000040 aabbccdd 5 00000000
c 0 00000040 00000000 0 00000000
c 1 00000044 cafef00d f 00000000
c 1 00000044 00000000 0 00000000
p 0 00000088 12345678 f 00000000
p 0 00000088 00000000 0 00000000
c 0 00000050 00000000 0 5a5a0001
c 1 00000164 deadbeef f 5a5a0002
s 0 0000000c 01020304 f 00000000
s 1 0000000c 00000000 0 00000000
s 1 00000005 00000000 0 00000000
g 0 00000001 00000000 0 00000000
c 0 00000050 00000000 0 00000000
c 1 00000040 00000000 0 77770040
g 0 00000001 00000001 0 00000000
h 0 00000006 55667788 f 00000000
s 1 00000006 00000000 0 00000000
g 0 00000000 00000000 0 00000000
i 0 00000000 00000000 0 00000000
c 0 00000040 00000000 0 00000000
c 1 00000050 00000000 0 13579bdf
